/* src/core_pkg.sv */
`default_nettype none
//**********************************************************
// Core pipeline types
// Word, strobe, register and op types for the load/store
// pipeline, with the load and store classifiers
//**********************************************************

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;

    // Op codes carried by each record from the execute stage
    typedef enum logic [3:0] {
        OP_ALU             = 4'h0,
        LOAD_BYTE          = 4'h1,
        LOAD_HALF          = 4'h2,
        LOAD_WORD          = 4'h3,
        LOAD_BYTE_UNSIGNED = 4'h4,
        LOAD_HALF_UNSIGNED = 4'h5,
        STORE_BYTE         = 4'h6,
        STORE_HALF         = 4'h7,
        STORE_WORD         = 4'h8
    } op_t;

    function automatic logic is_load(op_t op);
        case (op)
            LOAD_BYTE, LOAD_HALF, LOAD_WORD,
            LOAD_BYTE_UNSIGNED, LOAD_HALF_UNSIGNED:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic is_store(op_t op);
        case (op)
            STORE_BYTE, STORE_HALF, STORE_WORD:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/axi_pkg.sv */
`default_nettype none
//**********************************************************
// AXI-Lite encodings
// Bus widths and response codes for the data RAM bus
//**********************************************************

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [1:0] resp_t;

    // Only OKAY and SLVERR are ever returned by the RAM
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* src/store_align.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Store alignment
// Moves store data into its byte lane and sets the strobes
//**********************************************************

module store_align (
    input  core_pkg::op_t  op,
    input  core_pkg::word_t addr,
    input  core_pkg::word_t din,
    output core_pkg::word_t dout,
    output core_pkg::strb_t strb
);

    always_comb begin
        case (op)
            core_pkg::STORE_WORD: begin
                dout = din;
                strb = 4'b1111;
            end
            core_pkg::STORE_HALF: begin
                // Upper half when address bit 1 is set
                dout = din << {addr[1], 4'b0000};
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            core_pkg::STORE_BYTE: begin
                dout = din << {addr[1:0], 3'b000};
                strb = 4'b0001 << addr[1:0];
            end
            default: begin
                // Not a store, so nothing is written
                dout = din;
                strb = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/load_align.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Load alignment
// Picks the addressed lane and sign- or zero-extends it
//**********************************************************

module load_align (
    input  core_pkg::op_t   op,
    input  core_pkg::word_t addr,
    input  core_pkg::word_t din,
    output core_pkg::word_t dout
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = din[{addr[1:0], 3'b000} +: 8];
    assign half_lane = din[{addr[1], 4'b0000} +: 16];

    always_comb begin
        case (op)
            core_pkg::LOAD_BYTE:          dout = {{24{byte_lane[7]}}, byte_lane};
            core_pkg::LOAD_BYTE_UNSIGNED: dout = {24'h000000, byte_lane};
            core_pkg::LOAD_HALF:          dout = {{16{half_lane[15]}}, half_lane};
            core_pkg::LOAD_HALF_UNSIGNED: dout = {16'h0000, half_lane};
            // Word loads and anything else pass the bus word as is
            default:                      dout = din;
        endcase
    end

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Memory stage
// Turns pipeline records into AXI-Lite reads and writes and
// returns every record in order on the writeback stream
//**********************************************************

module mem_stage (
    input  logic                 aclk,
    input  logic                 aresetn,
    // Records from the execute stage
    input  logic                 src_tvalid,
    output logic                 src_tready,
    input  core_pkg::op_t        src_op,
    input  core_pkg::word_t      src_alu,
    input  core_pkg::word_t      src_rs2,
    input  core_pkg::reg_addr_t  src_rd,
    // Writeback records
    output logic                 wb_tvalid,
    input  logic                 wb_tready,
    output core_pkg::op_t        wb_op,
    output core_pkg::reg_addr_t  wb_rd_addr,
    output core_pkg::word_t      wb_rd_data,
    output logic                 wb_err,
    // AXI-Lite master
    output logic                 awvalid,
    input  logic                 awready,
    output core_pkg::word_t      awaddr,
    output logic                 wvalid,
    input  logic                 wready,
    output core_pkg::word_t      wdata,
    output core_pkg::strb_t      wstrb,
    input  logic                 bvalid,
    output logic                 bready,
    input  axi_pkg::resp_t       bresp,
    output logic                 arvalid,
    input  logic                 arready,
    output core_pkg::word_t      araddr,
    input  logic                 rvalid,
    output logic                 rready,
    input  core_pkg::word_t      rdata,
    input  axi_pkg::resp_t       rresp
);

    logic                accept;
    logic                write;
    logic                read;
    logic                pass;
    logic                b_done;
    logic                r_done;
    logic                reading;
    core_pkg::word_t     st_data;
    core_pkg::strb_t     st_strb;
    core_pkg::word_t     ld_data;
    // Saved fields of the access in flight
    core_pkg::op_t       acc_op;
    core_pkg::reg_addr_t acc_rd;
    core_pkg::word_t     acc_addr;

    assign accept = src_tvalid & src_tready;
    assign write  = accept & core_pkg::is_store(src_op);
    assign read   = accept & core_pkg::is_load(src_op);
    assign pass   = accept & ~core_pkg::is_store(src_op) & ~core_pkg::is_load(src_op);
    assign b_done = bvalid & bready;
    assign r_done = rvalid & rready;

    // Input waits while any response is still owed
    assign src_tready = ~bready & ~reading & wb_tready;
    assign rready     = wb_tready;

    store_align store_align_inst (
        .op   (src_op),
        .addr (src_alu),
        .din  (src_rs2),
        .dout (st_data),
        .strb (st_strb)
    );

    load_align load_align_inst (
        .op   (acc_op),
        .addr (acc_addr),
        .din  (rdata),
        .dout (ld_data)
    );

    // Nothing new is accepted while a channel is stalled, so these hold
    always_ff @(posedge aclk) begin
        if (write | read) begin
            acc_op   <= src_op;
            acc_rd   <= src_rd;
            acc_addr <= src_alu;
        end
        if (write) begin
            wdata <= st_data;
            wstrb <= st_strb;
        end
    end

    assign awaddr = acc_addr;
    assign araddr = acc_addr;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            if (write) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
                bready  <= 1'b1;
            end else begin
                if (awvalid && awready)
                    awvalid <= 1'b0;
                if (wvalid && wready)
                    wvalid <= 1'b0;
                if (b_done)
                    bready <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arvalid <= 1'b0;
            reading <= 1'b0;
        end else if (read) begin
            arvalid <= 1'b1;
            reading <= 1'b1;
        end else begin
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (r_done)
                reading <= 1'b0;
        end
    end

    // A store's record waits for its write response so it can carry the error
    always_ff @(posedge aclk) begin
        if (!aresetn)
            wb_tvalid <= 1'b0;
        else if (pass || b_done || r_done)
            wb_tvalid <= 1'b1;
        else if (wb_tready)
            wb_tvalid <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (pass) begin
            wb_op      <= src_op;
            wb_rd_addr <= src_rd;
            wb_rd_data <= src_alu;
            wb_err     <= 1'b0;
        end else if (b_done) begin
            wb_op      <= acc_op;
            wb_rd_addr <= acc_rd;
            wb_rd_data <= acc_addr;
            wb_err     <= (bresp == axi_pkg::RESP_SLVERR);
        end else if (r_done) begin
            wb_op      <= acc_op;
            wb_rd_addr <= acc_rd;
            wb_rd_data <= ld_data;
            wb_err     <= (rresp == axi_pkg::RESP_SLVERR);
        end
    end

endmodule

`default_nettype wire

/* src/axi_data_ram.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// AXI-Lite data RAM
// Word RAM with byte-strobe writes; addresses past the end
// answer SLVERR
//**********************************************************

module axi_data_ram #(
    parameter int DEPTH = 256
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [axi_pkg::ADDR_W-1:0]  awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [axi_pkg::DATA_W-1:0]  wdata,
    input  logic [axi_pkg::STRB_W-1:0]  wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output axi_pkg::resp_t              bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [axi_pkg::ADDR_W-1:0]  araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [axi_pkg::DATA_W-1:0]  rdata,
    output axi_pkg::resp_t              rresp
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam logic [axi_pkg::ADDR_W-3:0] LIMIT = (axi_pkg::ADDR_W - 2)'(DEPTH);

    logic [axi_pkg::DATA_W-1:0] mem [DEPTH];

    logic             wr_en;
    logic             rd_en;
    logic             wr_ok;
    logic             rd_ok;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Address and data are taken together, one write at a time
    assign awready = awvalid & wvalid & ~bvalid;
    assign wready  = awvalid & wvalid & ~bvalid;
    assign arready = ~rvalid;

    assign wr_en = awvalid & awready;
    assign rd_en = arvalid & arready;

    assign wr_ok  = awaddr[axi_pkg::ADDR_W-1:2] < LIMIT;
    assign rd_ok  = araddr[axi_pkg::ADDR_W-1:2] < LIMIT;
    assign wr_idx = awaddr[IDX_W+1:2];
    assign rd_idx = araddr[IDX_W+1:2];

    always_ff @(posedge aclk) begin
        if (wr_en && wr_ok) begin
            for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                if (wstrb[i])
                    mem[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // Out of range reads return zero data
    always_ff @(posedge aclk) begin
        if (wr_en)
            bresp <= wr_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        if (rd_en) begin
            rdata <= rd_ok ? mem[rd_idx] : '0;
            rresp <= rd_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_en)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/mem_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Memory subsystem
// Memory stage wired to its AXI-Lite data RAM
//**********************************************************

module mem_subsystem #(
    parameter int DEPTH = 256
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                src_tvalid,
    output logic                src_tready,
    input  core_pkg::op_t       src_op,
    input  core_pkg::word_t     src_alu,
    input  core_pkg::word_t     src_rs2,
    input  core_pkg::reg_addr_t src_rd,
    output logic                wb_tvalid,
    input  logic                wb_tready,
    output core_pkg::op_t       wb_op,
    output core_pkg::reg_addr_t wb_rd_addr,
    output core_pkg::word_t     wb_rd_data,
    output logic                wb_err
);

    logic            awvalid;
    logic            awready;
    core_pkg::word_t awaddr;
    logic            wvalid;
    logic            wready;
    core_pkg::word_t wdata;
    core_pkg::strb_t wstrb;
    logic            bvalid;
    logic            bready;
    axi_pkg::resp_t  bresp;
    logic            arvalid;
    logic            arready;
    core_pkg::word_t araddr;
    logic            rvalid;
    logic            rready;
    core_pkg::word_t rdata;
    axi_pkg::resp_t  rresp;

    mem_stage mem_stage_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .src_tvalid (src_tvalid),
        .src_tready (src_tready),
        .src_op     (src_op),
        .src_alu    (src_alu),
        .src_rs2    (src_rs2),
        .src_rd     (src_rd),
        .wb_tvalid  (wb_tvalid),
        .wb_tready  (wb_tready),
        .wb_op      (wb_op),
        .wb_rd_addr (wb_rd_addr),
        .wb_rd_data (wb_rd_data),
        .wb_err     (wb_err),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    axi_data_ram #(
        .DEPTH (DEPTH)
    ) axi_data_ram_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

`default_nettype wire

/* tests/mem_stage_props.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Memory stage properties
// Handshake and ordering rules checked inside mem_stage
//**********************************************************

module mem_stage_props (
    input logic                aclk,
    input logic                aresetn,
    input logic                src_tready,
    input logic                wb_tvalid,
    input logic                wb_tready,
    input core_pkg::op_t       wb_op,
    input core_pkg::reg_addr_t wb_rd_addr,
    input core_pkg::word_t     wb_rd_data,
    input logic                wb_err,
    input logic                awvalid,
    input logic                wvalid,
    input logic                bready,
    input logic                arvalid,
    input logic                rvalid
);

    // Address and data of a write are offered on the same edge
    aw_w_rise_together: assert property (
        @(posedge aclk) disable iff (!aresetn)
        $rose(awvalid) == $rose(wvalid)
    ) else $error("awvalid and wvalid did not rise on the same edge");

    // A read is open on the bus from arvalid until the RAM's data is taken
    no_accept_while_pending: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (bready || arvalid || rvalid) |-> !src_tready
    ) else $error("src_tready was high while a response was outstanding");

    // A stalled writeback record must not change under the consumer
    wb_held_until_ready: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (wb_tvalid && !wb_tready) |=>
            (wb_tvalid && $stable(wb_op) && $stable(wb_rd_addr)
             && $stable(wb_rd_data) && $stable(wb_err))
    ) else $error("writeback record changed before it was taken");

    no_read_and_write: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(arvalid && awvalid)
    ) else $error("arvalid and awvalid were high together");

endmodule

bind mem_stage mem_stage_props mem_stage_props_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .src_tready (src_tready),
    .wb_tvalid  (wb_tvalid),
    .wb_tready  (wb_tready),
    .wb_op      (wb_op),
    .wb_rd_addr (wb_rd_addr),
    .wb_rd_data (wb_rd_data),
    .wb_err     (wb_err),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .bready     (bready),
    .arvalid    (arvalid),
    .rvalid     (rvalid)
);

`default_nettype wire

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none
//**********************************************************
// Memory subsystem testbench
// Replays the case table through the memory stage under random
// writeback back-pressure and checks every writeback record
//**********************************************************

module mem_subsystem_tb;

    localparam int DEPTH           = 256;
    localparam int MAX_CASES       = 64;
    localparam int NAME_CHARS      = 24;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_CASE = 20;
    localparam int TAIL_CYCLES     = 10;
    localparam int SEED            = 32'h343d79b7;

    logic                aclk;
    logic                aresetn;
    logic                src_tvalid;
    logic                src_tready;
    core_pkg::op_t       src_op;
    core_pkg::word_t     src_alu;
    core_pkg::word_t     src_rs2;
    core_pkg::reg_addr_t src_rd;
    logic                wb_tvalid;
    logic                wb_tready;
    core_pkg::op_t       wb_op;
    core_pkg::reg_addr_t wb_rd_addr;
    core_pkg::word_t     wb_rd_data;
    logic                wb_err;

    // Case table loaded from the data file
    logic [8*NAME_CHARS-1:0] case_name [MAX_CASES];
    core_pkg::op_t           case_op   [MAX_CASES];
    core_pkg::word_t         case_alu  [MAX_CASES];
    core_pkg::word_t         case_rs2  [MAX_CASES];
    core_pkg::reg_addr_t     case_rd   [MAX_CASES];
    core_pkg::word_t         case_data [MAX_CASES];
    logic                    case_err  [MAX_CASES];

    int num_cases   = 0;
    int checked     = 0;
    int extra       = 0;
    int cycle_count = 0;

    mem_subsystem #(
        .DEPTH (DEPTH)
    ) mem_subsystem_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .src_tvalid (src_tvalid),
        .src_tready (src_tready),
        .src_op     (src_op),
        .src_alu    (src_alu),
        .src_rs2    (src_rs2),
        .src_rd     (src_rd),
        .wb_tvalid  (wb_tvalid),
        .wb_tready  (wb_tready),
        .wb_op      (wb_op),
        .wb_rd_addr (wb_rd_addr),
        .wb_rd_data (wb_rd_data),
        .wb_err     (wb_err)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    // Consumer is ready on about three cycles out of four
    always @(posedge aclk) begin
        #1 wb_tready = ($urandom % 4) != 0;
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > RESET_CYCLES + CYCLES_PER_CASE * num_cases + TAIL_CYCLES) begin
            $display("Finished with errors");
            $fatal(1, "Run timed out after %0d cycles with %0d of %0d records checked",
                   cycle_count, checked, num_cases);
        end
    end

    task automatic check_value(
        input logic [8*NAME_CHARS-1:0] name,
        input string                   field,
        input logic [31:0]             expected,
        input logic [31:0]             actual
    );
        if (expected !== actual) begin
            $display("[ERROR] %0s %0s expected %h actual %h", name, field, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Writeback record did not match");
        end
    endtask

    task automatic load_cases();
        int                      fd;
        int                      count;
        string                   line;
        logic [8*NAME_CHARS-1:0] name_val;
        logic [3:0]              op_val;
        logic [31:0]             alu_val;
        logic [31:0]             rs2_val;
        logic [4:0]              rd_val;
        logic [31:0]             data_val;
        logic                    err_val;
        fd = $fopen("tests/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("Finished with errors");
            $fatal(1, "Could not open the case file tests/mem_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            // Lines starting with a hash are column notes
            if (line.len() > 0 && line.getc(0) != "#" && num_cases < MAX_CASES) begin
                count = $sscanf(line, "%s %h %h %h %h %h %h", name_val, op_val,
                                alu_val, rs2_val, rd_val, data_val, err_val);
                if (count == 7) begin
                    case_name[num_cases] = name_val;
                    case_op[num_cases]   = core_pkg::op_t'(op_val);
                    case_alu[num_cases]  = alu_val;
                    case_rs2[num_cases]  = rs2_val;
                    case_rd[num_cases]   = rd_val;
                    case_data[num_cases] = data_val;
                    case_err[num_cases]  = err_val;
                    num_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Offers records in file order, sometimes after an idle cycle
    task automatic drive_records();
        int   idx;
        logic sent;
        idx = 0;
        while (idx < num_cases) begin
            if (src_tvalid || ($urandom % 4) != 0) begin
                src_tvalid = 1'b1;
                src_op     = case_op[idx];
                src_alu    = case_alu[idx];
                src_rs2    = case_rs2[idx];
                src_rd     = case_rd[idx];
            end
            @(negedge aclk);
            sent = src_tvalid && src_tready;
            @(posedge aclk);
            #1;
            if (sent) begin
                idx++;
                src_tvalid = 1'b0;
            end
        end
    endtask

    task automatic collect_records();
        int idx;
        idx = 0;
        while (idx < num_cases) begin
            @(negedge aclk);
            if (wb_tvalid && wb_tready) begin
                check_value(case_name[idx], "op", {28'h0, case_op[idx]}, {28'h0, wb_op});
                check_value(case_name[idx], "rd_addr", {27'h0, case_rd[idx]},
                            {27'h0, wb_rd_addr});
                check_value(case_name[idx], "rd_data", case_data[idx], wb_rd_data);
                check_value(case_name[idx], "err", {31'h0, case_err[idx]}, {31'h0, wb_err});
                idx++;
                checked = idx;
            end
        end
    endtask

    initial begin
        aresetn    = 1'b0;
        src_tvalid = 1'b0;
        src_op     = core_pkg::OP_ALU;
        src_alu    = '0;
        src_rs2    = '0;
        src_rd     = '0;
        wb_tready  = 1'b0;
        void'($urandom(SEED));
        load_cases();
        if (num_cases == 0) begin
            $display("Finished with errors");
            $fatal(1, "The case file holds no usable records");
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        #1 aresetn = 1'b1;
        fork
            drive_records();
            collect_records();
        join
        // Nothing more may come out once every record has been seen
        repeat (TAIL_CYCLES) begin
            @(negedge aclk);
            if (wb_tvalid)
                extra++;
        end
        if (checked == num_cases && extra == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Writeback showed %0d extra cycles of records after the last case", extra);
            $display("Finished with errors");
            $fatal(1, "Unexpected writeback records after the last case");
        end
    end

endmodule

`default_nettype wire

/* list.f */
src/core_pkg.sv
src/axi_pkg.sv
src/store_align.sv
src/load_align.sv
src/mem_stage.sv
src/axi_data_ram.sv
src/mem_subsystem.sv
tests/mem_stage_props.sv
tests/mem_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mem_subsystem_tb -f list.f -o mem_subsystem_sim \
    && ./obj_dir/mem_subsystem_sim \
    || { echo "Simulation run did not pass"; exit 1; }

/* tests/mem_cases.txt */
# name op alu rs2 rd exp_data exp_err, every field after the name in hex
# op 0 alu, 1 lb, 2 lh, 3 lw, 4 lbu, 5 lhu, 6 sb, 7 sh, 8 sw
alu_pass_a    0 12345678 deadbeef 01 12345678 0
alu_pass_b    0 ffffffff 00000000 1f ffffffff 0
sw_word       8 00000010 cafef00d 02 00000010 0
lw_word       3 00000010 00000000 03 cafef00d 0
alu_pass_c    0 00000000 aaaaaaaa 04 00000000 0
sw_base_20    8 00000020 11223344 05 00000020 0
sb_lane0      6 00000020 000000aa 06 00000020 0
lw_lane0      3 00000020 00000000 07 112233aa 0
sb_lane1      6 00000021 123456bb 08 00000021 0
sb_lane2      6 00000022 000000cc 09 00000022 0
lw_lane12     3 00000020 00000000 0a 11ccbbaa 0
sb_lane3      6 00000023 fffffedd 0b 00000023 0
lw_lane3      3 00000020 00000000 0c ddccbbaa 0
sw_base_24    8 00000024 55667788 0d 00000024 0
sh_low        7 00000024 0000abcd 0e 00000024 0
lw_half_low   3 00000024 00000000 0f 5566abcd 0
sh_high       7 00000026 9999ef01 10 00000026 0
lw_half_high  3 00000024 00000000 11 ef01abcd 0
lb_off0       1 00000020 00000000 12 ffffffaa 0
lb_off1       1 00000021 00000000 13 ffffffbb 0
lb_off2       1 00000022 00000000 14 ffffffcc 0
lb_off3       1 00000023 00000000 15 ffffffdd 0
lb_positive   1 00000026 00000000 16 00000001 0
lbu_off0      4 00000020 00000000 17 000000aa 0
lbu_off1      4 00000021 00000000 18 000000bb 0
lbu_off2      4 00000022 00000000 19 000000cc 0
lbu_off3      4 00000023 00000000 1a 000000dd 0
lh_off0       2 00000020 00000000 1b ffffbbaa 0
lh_off2       2 00000022 00000000 1c ffffddcc 0
sw_base_28    8 00000028 7fff0123 1d 00000028 0
lh_pos_off0   2 00000028 00000000 1e 00000123 0
lh_pos_off2   2 0000002a 00000000 1f 00007fff 0
lhu_off0      5 00000020 00000000 00 0000bbaa 0
lhu_off2      5 00000022 00000000 01 0000ddcc 0
sw_zero       8 00000000 0badf00d 02 00000000 0
sw_range      8 00000400 deadbeef 03 00000400 1
sb_range      6 00000401 000000ee 04 00000401 1
lw_range      3 00000400 00000000 05 00000000 1
lw_top        3 fffffffc 00000000 06 00000000 1
lw_zero       3 00000000 00000000 07 0badf00d 0
alu_pass_d    0 00000400 00000000 08 00000400 0
